// File: list.f
source/chipset_pkg.sv
source/slave_bus_if.sv
source/chip_select_decode.sv
source/wait_state_timer.sv
source/bus_ctrl_fsm.sv
source/scratch_ram.sv
source/io_regs.sv
source/chipset_bus.sv
test/chipset_bus_properties.sv
test/chipset_bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the chipset bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module chipset_bus_tb -f list.f \
    -o sim_chipset_bus \
    && ./obj_dir/sim_chipset_bus 2>&1 | tee sim.log
# The log decides pass or fail
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// File: source/bus_ctrl_fsm.sv
`timescale 1ns/10ps

module bus_ctrl_fsm import chipset_pkg::*; (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              req_i,
    input  word_t             addr_i,
    input  logic              we_i,
    input  word_t             wdata_i,
    input  mask_t             wmask_i,
    output logic              ack_o,
    output word_t             rdata_o,
    output logic              err_o,
    output word_t             dec_addr_o,
    input  chip_select_t      dec_cs_i,
    input  logic [WAIT_W-1:0] dec_wait_i,
    output logic              tmr_load_o,
    output logic [WAIT_W-1:0] tmr_count_o,
    input  logic              tmr_done_i,
    slave_bus_if.ctrl         bus
);

    typedef enum logic [2:0] {IDLE, WAIT, ACCESS, ACK, RELEASE} state_t;

    state_t       state_q;
    state_t       state_d;
    logic         start;
    word_t        slave_rdata;

    // Latched request and its decode
    word_t        addr_q;
    word_t        wdata_q;
    mask_t        wmask_q;
    logic         we_q;
    chip_select_t cs_q;

    // Response held while ack is high
    word_t        rdata_q;
    logic         err_q;

    // New request sampled in IDLE
    assign start = (state_q == IDLE) && req_i;

    // Decoder sees the live address in IDLE so the wait count is ready at the sampling edge
    assign dec_addr_o  = (state_q == IDLE) ? addr_i : addr_q;
    assign tmr_load_o  = start;
    assign tmr_count_o = dec_wait_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (tmr_done_i) begin
                    state_d = ACCESS;
                end
            end
            ACCESS:  state_d = ACK;
            // Master may hold req as long as it likes
            ACK: begin
                if (!req_i) begin
                    state_d = RELEASE;
                end
            end
            RELEASE: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // Return path chosen by the latched select, zero when unmapped
    always_comb begin
        if (cs_q.ram) begin
            slave_rdata = bus.ram_rdata;
        end else if (cs_q.irq || cs_q.display || cs_q.switches) begin
            slave_rdata = bus.io_rdata;
        end else begin
            slave_rdata = '0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            rdata_q <= '0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // Response captured in the access cycle
            if (state_q == ACCESS) begin
                rdata_q <= slave_rdata;
                err_q   <= (cs_q == '0);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            wmask_q <= wmask_i;
            we_q    <= we_i;
            cs_q    <= dec_cs_i;
        end
    end

    // Single strobe cycle, suppressed for unmapped addresses
    assign bus.strobe = (state_q == ACCESS) && (cs_q != '0);
    assign bus.cs     = bus.strobe ? cs_q : '0;
    assign bus.addr   = addr_q;
    assign bus.wdata  = wdata_q;
    assign bus.wmask  = wmask_q;
    assign bus.we     = we_q;

    assign ack_o   = (state_q == ACK);
    assign rdata_o = rdata_q;
    assign err_o   = err_q;

endmodule

// File: source/chip_select_decode.sv
`timescale 1ns/10ps

module chip_select_decode import chipset_pkg::*; #(
    parameter int RAM_WAIT = 3,
    parameter int IO_WAIT  = 1
) (
    input  word_t              addr_i,
    output chip_select_t       cs_o,
    output logic [WAIT_W-1:0]  wait_o
);

    // Wait counts sized to the timer
    localparam logic [WAIT_W-1:0] RAM_WAIT_CNT = WAIT_W'(RAM_WAIT);
    localparam logic [WAIT_W-1:0] IO_WAIT_CNT  = WAIT_W'(IO_WAIT);

    // Region map
    // 1xxxxxxx  scratch RAM
    // FFFF00xx  interrupt controller
    // FFFF02xx  seven-segment display
    // FFFF03xx  switches
    // Anything else is unmapped, no select and no wait
    always_comb begin
        cs_o   = '{default: '0};
        wait_o = '0;
        unique casez (addr_i)
            {RAM_BASE_NIBBLE, 28'h???????}: begin
                cs_o.ram = 1'b1;
                wait_o   = RAM_WAIT_CNT;
            end
            {IO_BASE[31:16], IRQ_PAGE, 8'h??}: begin
                cs_o.irq = 1'b1;
                wait_o   = IO_WAIT_CNT;
            end
            {IO_BASE[31:16], DISPLAY_PAGE, 8'h??}: begin
                cs_o.display = 1'b1;
                wait_o       = IO_WAIT_CNT;
            end
            {IO_BASE[31:16], SWITCHES_PAGE, 8'h??}: begin
                cs_o.switches = 1'b1;
                wait_o        = IO_WAIT_CNT;
            end
            default: ;
        endcase
    end

endmodule

// File: source/chipset_bus.sv
`timescale 1ns/10ps

module chipset_bus import chipset_pkg::*; #(
    parameter int RAM_WORDS = 64,
    parameter int RAM_WAIT  = 3,
    parameter int IO_WAIT   = 1
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    // Four-phase master port
    input  logic       req_i,
    input  word_t      addr_i,
    input  logic       we_i,
    input  word_t      wdata_i,
    input  mask_t      wmask_i,
    output logic       ack_o,
    output word_t      rdata_o,
    output logic       err_o,
    // Board I/O
    input  word_t      switches_i,
    input  logic [3:0] irq_lines_i,
    output logic       irq_o,
    output logic       disp_enable_o,
    output word_t      disp_value_o
);

    word_t             dec_addr;
    chip_select_t      dec_cs;
    logic [WAIT_W-1:0] dec_wait;
    logic              tmr_load;
    logic [WAIT_W-1:0] tmr_count;
    logic              tmr_done;

    // Controller to data modules
    slave_bus_if u_bus ();

    chip_select_decode #(
        .RAM_WAIT (RAM_WAIT),
        .IO_WAIT  (IO_WAIT)
    ) u_decode (
        .addr_i (dec_addr),
        .cs_o   (dec_cs),
        .wait_o (dec_wait)
    );

    wait_state_timer u_timer (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .load_i   (tmr_load),
        .count_i  (tmr_count),
        .done_o   (tmr_done)
    );

    bus_ctrl_fsm u_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .addr_i      (addr_i),
        .we_i        (we_i),
        .wdata_i     (wdata_i),
        .wmask_i     (wmask_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .err_o       (err_o),
        .dec_addr_o  (dec_addr),
        .dec_cs_i    (dec_cs),
        .dec_wait_i  (dec_wait),
        .tmr_load_o  (tmr_load),
        .tmr_count_o (tmr_count),
        .tmr_done_i  (tmr_done),
        .bus         (u_bus.ctrl)
    );

    scratch_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk_i (clk_i),
        .bus   (u_bus.slave)
    );

    io_regs u_io (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .bus           (u_bus.slave),
        .switches_i    (switches_i),
        .irq_lines_i   (irq_lines_i),
        .irq_o         (irq_o),
        .disp_enable_o (disp_enable_o),
        .disp_value_o  (disp_value_o)
    );

endmodule

// File: source/chipset_pkg.sv
package chipset_pkg;

    // Bus word for address, data and registers
    typedef logic [31:0] word_t;

    // One bit per byte lane
    typedef logic [3:0] mask_t;

    // Offset of a register inside a 256-byte I/O page
    typedef logic [7:0] offset_t;

    // One bit per mapped region, all zero when unmapped
    typedef struct packed {
        logic ram;
        logic irq;
        logic display;
        logic switches;
    } chip_select_t;

    // Width of a wait-state count
    localparam int WAIT_W = 4;

    // Region patterns
    localparam logic [3:0] RAM_BASE_NIBBLE = 4'h1;
    localparam word_t      IO_BASE         = 32'hFFFF_0000;
    localparam offset_t    IRQ_PAGE        = 8'h00;
    localparam offset_t    DISPLAY_PAGE    = 8'h02;
    localparam offset_t    SWITCHES_PAGE   = 8'h03;

    // Interrupt controller registers
    localparam offset_t REG_IRQ_PENDING = 8'h00;
    localparam offset_t REG_IRQ_ENABLED = 8'h04;
    localparam offset_t REG_IRQ_ACTIVE  = 8'h08;

    // Seven-segment display registers
    localparam offset_t REG_DISP_CTRL  = 8'h00;
    localparam offset_t REG_DISP_VALUE = 8'h04;

    // Replace the byte lanes selected by mask
    function automatic word_t merge_bytes(word_t old_word, word_t new_word, mask_t mask);
        word_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: source/io_regs.sv
`timescale 1ns/10ps

module io_regs import chipset_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    slave_bus_if.slave bus,
    input  word_t      switches_i,
    input  logic [3:0] irq_lines_i,
    output logic       irq_o,
    output logic       disp_enable_o,
    output word_t      disp_value_o
);

    offset_t    offset;
    logic       wr;
    logic [3:0] pend_clr;
    logic [3:0] active;

    logic [3:0] pending_q;
    logic [3:0] enabled_q;
    logic       irq_q;
    logic       disp_enable_q;
    word_t      disp_value_q;

    // Register offset inside the selected page
    assign offset = bus.addr[7:0];
    assign wr     = bus.strobe && bus.we;
    assign active = pending_q & enabled_q;

    // Write 1 to clear pending, byte lane 0 only
    assign pend_clr = (wr && bus.cs.irq && offset == REG_IRQ_PENDING && bus.wmask[0])
                    ? bus.wdata[3:0] : 4'b0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q     <= '0;
            enabled_q     <= '0;
            irq_q         <= 1'b0;
            disp_enable_q <= 1'b0;
            disp_value_q  <= '0;
        end else begin
            // A line still high sets its bit again over a clear
            pending_q <= (pending_q & ~pend_clr) | irq_lines_i;
            irq_q     <= |active;
            if (wr && bus.cs.irq && offset == REG_IRQ_ENABLED && bus.wmask[0]) begin
                enabled_q <= bus.wdata[3:0];
            end
            if (wr && bus.cs.display && offset == REG_DISP_CTRL && bus.wmask[0]) begin
                disp_enable_q <= bus.wdata[0];
            end
            if (wr && bus.cs.display && offset == REG_DISP_VALUE) begin
                disp_value_q <= merge_bytes(disp_value_q, bus.wdata, bus.wmask);
            end
        end
    end

    // Read mux by page select and offset
    // Switches are read-only, unused offsets read zero
    always_comb begin
        bus.io_rdata = '0;
        if (bus.cs.irq) begin
            case (offset)
                REG_IRQ_PENDING: bus.io_rdata = word_t'(pending_q);
                REG_IRQ_ENABLED: bus.io_rdata = word_t'(enabled_q);
                REG_IRQ_ACTIVE:  bus.io_rdata = word_t'(active);
                default: ;
            endcase
        end else if (bus.cs.display) begin
            case (offset)
                REG_DISP_CTRL:  bus.io_rdata = word_t'(disp_enable_q);
                REG_DISP_VALUE: bus.io_rdata = disp_value_q;
                default: ;
            endcase
        end else if (bus.cs.switches && offset == '0) begin
            bus.io_rdata = switches_i;
        end
    end

    assign irq_o         = irq_q;
    assign disp_enable_o = disp_enable_q;
    assign disp_value_o  = disp_value_q;

endmodule

// File: source/scratch_ram.sv
`timescale 1ns/10ps

module scratch_ram import chipset_pkg::*; #(
    parameter int RAM_WORDS = 64
) (
    input  logic       clk_i,
    slave_bus_if.slave bus
);

    // Depth is a power of two, so the index slice wraps the address
    localparam int IDX_W = $clog2(RAM_WORDS);

    word_t             mem [RAM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic              wr_en;

    // Word index from the byte address
    assign idx = bus.addr[IDX_W+1:2];

    assign wr_en = bus.strobe && bus.cs.ram && bus.we;

    // Byte-masked write on the strobe edge
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[idx] <= merge_bytes(mem[idx], bus.wdata, bus.wmask);
        end
    end

    // Asynchronous read
    assign bus.ram_rdata = mem[idx];

endmodule

// File: source/slave_bus_if.sv
`timescale 1ns/10ps

interface slave_bus_if import chipset_pkg::*; ();

    // Access bundle, valid while strobe is high
    chip_select_t cs;
    word_t        addr;
    word_t        wdata;
    mask_t        wmask;
    logic         we;
    logic         strobe;

    // Read data, one return path per data module
    word_t        ram_rdata;
    word_t        io_rdata;

    modport ctrl (
        output cs, addr, wdata, wmask, we, strobe,
        input  ram_rdata, io_rdata
    );

    modport slave (
        input  cs, addr, wdata, wmask, we, strobe,
        output ram_rdata, io_rdata
    );

endinterface

// File: source/wait_state_timer.sv
`timescale 1ns/10ps

module wait_state_timer import chipset_pkg::*; (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              load_i,
    input  logic [WAIT_W-1:0] count_i,
    output logic              done_o
);

    logic [WAIT_W-1:0] cnt_q;

    // Reload on request, otherwise count down to zero and hold
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= count_i;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Elapsed once the counter sits at zero
    // A reload in the same cycle starts a new wait
    assign done_o = !load_i && (cnt_q == '0);

endmodule

// File: test/chipset_bus_properties.sv
`timescale 1ns/10ps

module chipset_bus_properties import chipset_pkg::*; (
    input logic         clk_i,
    input logic         arst_n_i,
    input logic         req_i,
    input logic         ack_i,
    input logic         err_i,
    input logic         strobe_i,
    input chip_select_t cs_i
);

    // Failed assertions so far, read by the testbench at the end of the run
    int fail_count = 0;

    // Ack rises only while the master holds req
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(ack_i) |-> req_i)
        else begin
            $error("ack rose while req was low");
            fail_count++;
        end

    // Ack drops only once the master has released req
    ack_falls_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(ack_i) |-> $past(!req_i))
        else begin
            $error("ack fell while req was still high");
            fail_count++;
        end

    // At most one region selected
    cs_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(cs_i))
        else begin
            $error("more than one chip select active");
            fail_count++;
        end

    // Each strobe is answered by a fresh error-free ack
    strobe_then_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        strobe_i |=> $rose(ack_i) && !err_i)
        else begin
            $error("strobe not followed by a successful ack");
            fail_count++;
        end

    // A successful ack always had its strobe, an error ack never did
    ack_had_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(ack_i) |-> ($past(strobe_i) == !err_i))
        else begin
            $error("ack without the matching strobe");
            fail_count++;
        end

endmodule

bind bus_ctrl_fsm chipset_bus_properties u_props (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .ack_i    (ack_o),
    .err_i    (err_o),
    .strobe_i (bus.strobe),
    .cs_i     (bus.cs)
);

// File: test/chipset_bus_stimulus.txt
# op addr wdata wmask switches irq_lines, then expected rdata err irq_o
# All fields hex, expected rdata is not compared on writes
W 10000000 11223344 F 00000000 0 00000000 0 0
W 10000004 55667788 F 00000000 0 00000000 0 0
R 10000000 00000000 0 00000000 0 11223344 0 0
W 10000104 CAFEF00D F 00000000 0 00000000 0 0
R 10000004 00000000 0 00000000 0 CAFEF00D 0 0
W 10000000 AABBCCDD 5 00000000 0 00000000 0 0
R 10000100 00000000 0 00000000 0 11BB33DD 0 0
W FFFF0204 12345678 F 00000000 0 00000000 0 0
W FFFF0200 00000001 1 00000000 0 00000000 0 0
R FFFF0204 00000000 0 00000000 0 12345678 0 0
R FFFF0200 00000000 0 00000000 0 00000001 0 0
W FFFF0300 FFFFFFFF F A5A5F00F 0 00000000 0 0
R FFFF0300 00000000 0 A5A5F00F 0 A5A5F00F 0 0
R FFFF0000 00000000 0 A5A5F00F 4 00000004 0 0
W FFFF0004 00000006 1 A5A5F00F 4 00000000 0 1
R FFFF0008 00000000 0 A5A5F00F 0 00000004 0 1
W FFFF0000 00000004 1 A5A5F00F 0 00000000 0 0
R FFFF0000 00000000 0 A5A5F00F 0 00000000 0 0
R 00000000 00000000 0 A5A5F00F 0 00000000 1 0
W FFFF0104 FFFFFFFF F A5A5F00F 0 00000000 1 0
R FFFF0204 00000000 0 A5A5F00F 0 12345678 0 0

// File: test/chipset_bus_tb.sv
`timescale 1ns/10ps

module chipset_bus_tb import chipset_pkg::*; ();

    localparam int    RAM_WORDS    = 64;
    localparam int    RAM_WAIT     = 3;
    localparam int    IO_WAIT      = 1;
    localparam int    RESET_CYCLES = 3;
    localparam int    RNG_SEED     = 46594;
    localparam string STIM_FILE    = "test/chipset_bus_stimulus.txt";

    logic       clk;
    logic       arst_n;
    logic       req;
    word_t      addr;
    logic       we;
    word_t      wdata;
    mask_t      wmask;
    logic       ack;
    word_t      rdata;
    logic       err;
    word_t      switches;
    logic [3:0] irq_lines;
    logic       irq;
    logic       disp_enable;
    word_t      disp_value;

    // One entry per stimulus line
    logic       is_write_q[$];
    word_t      addr_q[$];
    word_t      wdata_q[$];
    mask_t      mask_q[$];
    word_t      sw_q[$];
    logic [3:0] irq_in_q[$];
    word_t      exp_rdata_q[$];
    logic       exp_err_q[$];
    logic       exp_irq_q[$];
    int         num_tx;

    // Expected display state, tracked from the writes
    logic       exp_disp_en;
    word_t      exp_disp_val;

    chipset_bus #(
        .RAM_WORDS (RAM_WORDS),
        .RAM_WAIT  (RAM_WAIT),
        .IO_WAIT   (IO_WAIT)
    ) u_dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .req_i         (req),
        .addr_i        (addr),
        .we_i          (we),
        .wdata_i       (wdata),
        .wmask_i       (wmask),
        .ack_o         (ack),
        .rdata_o       (rdata),
        .err_o         (err),
        .switches_i    (switches),
        .irq_lines_i   (irq_lines),
        .irq_o         (irq),
        .disp_enable_o (disp_enable),
        .disp_value_o  (disp_value)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // Byte lanes with a mask bit take the new data
    function automatic word_t apply_byte_mask(word_t old_val, word_t new_val, mask_t mask);
        word_t bit_mask;
        bit_mask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old_val & ~bit_mask) | (new_val & bit_mask);
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        string op;
        word_t f_addr;
        word_t f_wdata;
        word_t f_mask;
        word_t f_sw;
        word_t f_irq;
        word_t f_rdata;
        word_t f_err;
        word_t f_irqo;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            $display("Test failures found");
            $fatal(1);
        end
        // Comment lines start with #
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", op, f_addr, f_wdata, f_mask,
                            f_sw, f_irq, f_rdata, f_err, f_irqo);
                if (n == 9) begin
                    is_write_q.push_back(op == "W");
                    addr_q.push_back(f_addr);
                    wdata_q.push_back(f_wdata);
                    mask_q.push_back(f_mask[3:0]);
                    sw_q.push_back(f_sw);
                    irq_in_q.push_back(f_irq[3:0]);
                    exp_rdata_q.push_back(f_rdata);
                    exp_err_q.push_back(f_err[0]);
                    exp_irq_q.push_back(f_irqo[0]);
                end
            end
        end
        $fclose(fd);
        num_tx = is_write_q.size();
    endtask

    // Display registers as a successful write leaves them
    task automatic update_display_model(input int idx);
        if (is_write_q[idx] && !exp_err_q[idx]) begin
            if (addr_q[idx] == 32'hFFFF_0200 && mask_q[idx][0]) begin
                exp_disp_en = wdata_q[idx][0];
            end
            if (addr_q[idx] == 32'hFFFF_0204) begin
                exp_disp_val = apply_byte_mask(exp_disp_val, wdata_q[idx], mask_q[idx]);
            end
        end
    endtask

    task automatic run_transaction(input int idx);
        int    hold;
        // Every fourth transaction releases req late
        hold = (idx % 4 == 3) ? 4 : 0;
        @(posedge clk);
        req       <= 1'b1;
        we        <= is_write_q[idx];
        addr      <= addr_q[idx];
        wdata     <= wdata_q[idx];
        wmask     <= mask_q[idx];
        switches  <= sw_q[idx];
        irq_lines <= irq_in_q[idx];
        // Outputs sampled on the falling edge
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        if (!is_write_q[idx]) begin
            check_word("rdata_o", exp_rdata_q[idx], rdata);
        end
        check_flag("err_o", exp_err_q[idx], err);
        // Response must stay put while req is held
        repeat (hold) begin
            @(negedge clk);
            check_flag("ack_o", 1'b1, ack);
            check_flag("err_o", exp_err_q[idx], err);
            if (!is_write_q[idx]) begin
                check_word("rdata_o", exp_rdata_q[idx], rdata);
            end
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        while (ack) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        check_flag("irq_o", exp_irq_q[idx], irq);
        update_display_model(idx);
        check_flag("disp_enable_o", exp_disp_en, disp_enable);
        check_word("disp_value_o", exp_disp_val, disp_value);
    endtask

    task automatic watchdog(input int limit_cycles);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout, the req/ack handshake did not finish within %0d cycles", limit_cycles);
        $display("Test failures found");
        $fatal(1);
    endtask

    initial begin
        int idle;
        int limit;
        clk          = 1'b0;
        arst_n       = 1'b0;
        req          = 1'b0;
        addr         = '0;
        we           = 1'b0;
        wdata        = '0;
        wmask        = '0;
        switches     = '0;
        irq_lines    = '0;
        exp_disp_en  = 1'b0;
        exp_disp_val = '0;
        void'($urandom(RNG_SEED));
        load_stimulus();
        if (num_tx == 0) begin
            $display("The stimulus file holds no transactions");
            $display("Test failures found");
            $fatal(1);
        end
        // Budget per transaction covers the longest wait plus handshake and idle gaps
        limit = num_tx * (RAM_WAIT + 12) + RESET_CYCLES + 8;
        fork
            watchdog(limit);
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < num_tx; i++) begin
            idle = $urandom % 4;
            repeat (idle) @(posedge clk);
            run_transaction(i);
        end
        if (u_dut.u_ctrl.u_props.fail_count != 0) begin
            $display("Bus protocol assertions failed during the run");
            $display("Test failures found");
            $fatal(1);
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule
